// ==== verilog/spwPkg.sv ====
////////////////////////////////////////////////////////////
// Shared link definitions: character kinds, one-hot link
// states, N-char FIFO payload and host register offsets
////////////////////////////////////////////////////////////

package spwPkg;

  // Kind of a link character, already split out upstream
  typedef enum logic [2:0] {
    KindData = 3'd0,  // Data byte
    KindEop  = 3'd1,  // Normal end of packet
    KindEep  = 3'd2,  // Error end of packet
    KindEsc  = 3'd3,  // Escape, pairs with the next character
    KindFct  = 3'd4   // Flow control token
  } spwCharKind;

  // Link FSM states, one-hot, same layout as status bits 5:0
  typedef enum logic [5:0] {
    StErrorReset = 6'b000001,
    StErrorWait  = 6'b000010,
    StReady      = 6'b000100,
    StStarted    = 6'b001000,
    StConnecting = 6'b010000,
    StRun        = 6'b100000
  } spwState;

  // End marker of an N-char
  localparam logic [1:0] EndNone = 2'd0;
  localparam logic [1:0] EndEop  = 2'd1;
  localparam logic [1:0] EndEep  = 2'd2;

  // One N-char as held in the receive FIFO
  typedef struct packed {
    logic [1:0] endMark;  // EndNone, EndEop or EndEep
    logic [7:0] data;     // Data byte, don't care on a marker
  } spwNchar;

  // AXI4-Lite byte offsets
  localparam int RegAddrW = 4;
  localparam logic [RegAddrW-1:0] RegCtrl   = 4'h0;
  localparam logic [RegAddrW-1:0] RegStatus = 4'h4;
  localparam logic [RegAddrW-1:0] RegData   = 4'h8;

endpackage

// ==== verilog/spwRxDecoder.sv ====
////////////////////////////////////////////////////////////
// Receive character decoder: parity check, ESC pairing,
// event pulses to the link FSM and N-char push to the FIFO
////////////////////////////////////////////////////////////

module spwRxDecoder import spwPkg::*; (
  input  logic       gclk,
  input  logic       reset,
  input  logic       rstRx,       // Held in ErrorReset
  input  logic       rxValid_i,
  input  spwCharKind rxKind_i,
  input  logic [7:0] rxData_i,
  input  logic       rxParity_i,
  input  logic       inRun,
  output logic       pushValid,
  output spwNchar    pushData,
  output logic       gotBit,
  output logic       gotNull,
  output logic       gotFct,
  output logic       gotNchar,
  output logic       gotTime,
  output logic       errPar,
  output logic       errEsc
);

  logic       escPend;   // ESC seen, waiting for its partner
  logic       chOk;      // Valid character with good parity
  logic       isNchar;
  logic [1:0] endMark;

  assign chOk    = rxValid_i && (^{rxParity_i, rxData_i});  // Odd parity
  assign isNchar = rxKind_i inside {KindData, KindEop, KindEep};

  always_comb
  begin
    case (rxKind_i)
      KindEop: endMark = EndEop;
      KindEep: endMark = EndEep;
      default: endMark = EndNone;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Event pulses, one cycle after the character

  always_ff @(posedge gclk)
  begin
    if (reset || rstRx)
    begin
      escPend   <= 1'b0;
      pushValid <= 1'b0;
      gotBit    <= 1'b0;
      gotNull   <= 1'b0;
      gotFct    <= 1'b0;
      gotNchar  <= 1'b0;
      gotTime   <= 1'b0;
      errPar    <= 1'b0;
      errEsc    <= 1'b0;
    end
    else
    begin
      gotBit   <= rxValid_i;                  // Any character at all
      errPar   <= rxValid_i && !chOk;
      // Escaped pairs
      gotNull  <= chOk && escPend && rxKind_i == KindFct;
      gotTime  <= chOk && escPend && rxKind_i == KindData;
      errEsc   <= chOk && escPend && !(rxKind_i inside {KindFct, KindData});
      // Plain characters
      gotFct   <= chOk && !escPend && rxKind_i == KindFct;
      gotNchar <= chOk && !escPend && isNchar;
      pushValid <= chOk && !escPend && isNchar && inRun;  // Dropped outside Run
      if (rxValid_i)
        escPend <= chOk && !escPend && rxKind_i == KindEsc;  // Any next char ends it
    end
  end

  always_ff @(posedge gclk)
  begin
    if (rxValid_i)
    begin
      pushData.data    <= rxData_i;
      pushData.endMark <= endMark;
    end
  end

endmodule

// ==== verilog/spwRxFifo.sv ====
////////////////////////////////////////////////////////////
// Synchronous FIFO, payload given as a type parameter,
// occupancy level output and flush
////////////////////////////////////////////////////////////

module spwRxFifo #(
  parameter type PayloadT  = logic [7:0],
  parameter int  FifoDepth = 16
) (
  input  logic                           gclk,
  input  logic                           reset,
  input  logic                           flush,
  input  logic                           pushValid,
  input  PayloadT                        pushData,
  input  logic                           popEn,
  output PayloadT                        popData,
  output logic                           empty,
  output logic [$clog2(FifoDepth+1)-1:0] level
);

  localparam int PtrW   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int LevelW = $clog2(FifoDepth + 1);

  PayloadT         mem [FifoDepth];
  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic            full;
  logic            doPush;
  logic            doPop;

  // Wrap at depth, any depth allowed
  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = level == LevelW'(FifoDepth);
  assign empty   = level == '0;
  assign doPush  = pushValid && !full;   // Push into a full FIFO is lost
  assign doPop   = popEn && !empty;
  assign popData = mem[rdPtr];           // Head shows without a pop

  always_ff @(posedge gclk)
  begin
    if (reset || flush)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      level <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= nextPtr(wrPtr);
      if (doPop)
        rdPtr <= nextPtr(rdPtr);
      level <= level + LevelW'(doPush) - LevelW'(doPop);
    end
  end

  always_ff @(posedge gclk)
  begin
    if (doPush)
      mem[wrPtr] <= pushData;
  end

endmodule

// ==== verilog/spwLinkFsm.sv ====
////////////////////////////////////////////////////////////
// Link state machine, ErrorReset through Run, with the
// timeout timer, sequence error and transmit enable
////////////////////////////////////////////////////////////

module spwLinkFsm import spwPkg::*; #(
  parameter int ResetTicks = 10,   // 6.4 us equivalent
  parameter int WaitTicks  = 20    // 12.8 us equivalent
) (
  input  logic    gclk,
  input  logic    reset,
  input  logic    linkStart,
  input  logic    linkDisable,
  input  logic    autoStart,
  input  logic    rxDisc,
  input  logic    gotBit,
  input  logic    gotNull,
  input  logic    gotFct,
  input  logic    gotNchar,
  input  logic    gotTime,
  input  logic    errPar,
  input  logic    errEsc,
  input  logic    errCrd,
  output spwState linkState,
  output logic    enTx,
  output logic    rstRx,
  output logic    linkErr
);

  localparam int MaxTicks = (ResetTicks > WaitTicks) ? ResetTicks : WaitTicks;
  localparam int TimerW   = $clog2(MaxTicks + 1);

  spwState           stateNxt;
  logic              hasGotNull;
  logic              hasGotBit;
  logic              errSeq;
  logic              linkEn;
  logic              forceReset;
  logic              charErr;
  logic              resetDone;
  logic              waitDone;
  logic [TimerW-1:0] timer;

  assign linkEn     = !linkDisable && (linkStart || (autoStart && hasGotNull));
  assign forceReset = linkDisable || rxDisc;
  assign resetDone  = timer == TimerW'(ResetTicks);
  assign waitDone   = timer == TimerW'(WaitTicks);

  // Errors before Connecting, counted only once the line is alive
  assign charErr = (hasGotBit && errPar)
                || (hasGotNull && (errEsc || gotFct || gotNchar || gotTime));

  assign rstRx = linkState == StErrorReset;
  assign enTx  = linkState inside {StStarted, StConnecting, StRun};

  ////////////////////////////////////////////////////////////
  // First bit / first NULL flags and sequence error

  always_ff @(posedge gclk)
  begin
    if (reset || linkState == StErrorReset)
    begin
      hasGotNull <= 1'b0;
      hasGotBit  <= 1'b0;
    end
    else
    begin
      if (gotNull)
        hasGotNull <= 1'b1;
      if (gotBit)
        hasGotBit <= 1'b1;
    end
  end

  always_ff @(posedge gclk)
  begin
    if (reset)
      errSeq <= 1'b0;
    else
      errSeq <= (gotFct && linkState inside {StErrorWait, StReady, StStarted})
             || (gotNchar && linkState != StRun);   // N-char only legal in Run
  end

  ////////////////////////////////////////////////////////////
  // Next state

  always_comb
  begin
    stateNxt = linkState;
    linkErr  = 1'b0;
    case (linkState)
      StErrorReset:
        if (resetDone)
          stateNxt = StErrorWait;
      StErrorWait:
        if (charErr)
          stateNxt = StErrorReset;
        else if (waitDone)
          stateNxt = StReady;
      StReady:
        if (charErr)
          stateNxt = StErrorReset;
        else if (linkEn)
          stateNxt = StStarted;
      StStarted:
        if (charErr || waitDone)              // No NULL in time
          stateNxt = StErrorReset;
        else if (gotNull)
          stateNxt = StConnecting;
      StConnecting:
        if (errPar || errEsc || gotNchar || gotTime || waitDone)
          stateNxt = StErrorReset;            // Silent, not yet a link
        else if (gotFct)
          stateNxt = StRun;
      StRun:
        if (errPar || errEsc || errCrd || errSeq || rxDisc)
        begin
          linkErr  = 1'b1;                    // Reported to the host
          stateNxt = StErrorReset;
        end
      default:
        stateNxt = StErrorReset;
    endcase
    if (forceReset)
      stateNxt = StErrorReset;
  end

  always_ff @(posedge gclk)
  begin
    if (reset)
      linkState <= StErrorReset;
    else
      linkState <= stateNxt;
  end

  // Cycles spent in the current state, held while forced
  always_ff @(posedge gclk)
  begin
    if (reset || forceReset || stateNxt != linkState)
      timer <= '0;
    else if (timer != TimerW'(MaxTicks))
      timer <= timer + 1'b1;
  end

endmodule

// ==== verilog/spwTxEncoder.sv ====
////////////////////////////////////////////////////////////
// Transmit encoder: NULLs while enabled, FCTs for free FIFO
// space in Run, outstanding credit and credit error
////////////////////////////////////////////////////////////

module spwTxEncoder import spwPkg::*; #(
  parameter int FifoDepth = 16
) (
  input  logic                           gclk,
  input  logic                           reset,
  input  logic                           enTx,
  input  logic                           inRun,
  input  logic                           gotNchar,
  input  logic [$clog2(FifoDepth+1)-1:0] level,
  input  logic                           txReady_i,
  output logic                           txValid_o,
  output spwCharKind                     txKind_o,
  output logic                           errCrd
);

  localparam int LevelW = $clog2(FifoDepth + 1);
  localparam int CrdW   = LevelW + 1;      // Room for credit plus 8

  logic [CrdW-1:0] credit;                 // N-chars the far end may still send
  logic [CrdW-1:0] creditNxt;
  logic [CrdW-1:0] freeSlots;
  logic            nullPend;               // ESC out, FCT half of NULL next
  logic            loadNext;
  logic            fctDue;
  logic            sendFct;

  assign freeSlots = CrdW'(FifoDepth) - CrdW'(level);
  assign fctDue    = inRun && (freeSlots >= credit + CrdW'(8));
  assign loadNext  = !txValid_o || txReady_i;    // Slot empty or taken this cycle
  assign sendFct   = loadNext && !nullPend && fctDue;

  always_comb
  begin
    creditNxt = credit;
    if (sendFct)
      creditNxt = creditNxt + CrdW'(8);    // Granted when loaded, never dropped
    if (gotNchar && credit != '0)
      creditNxt = creditNxt - 1'b1;
  end

  always_ff @(posedge gclk)
  begin
    if (reset || !enTx)
    begin
      txValid_o <= 1'b0;
      nullPend  <= 1'b0;
      credit    <= '0;
      errCrd    <= 1'b0;
    end
    else
    begin
      credit <= creditNxt;
      errCrd <= gotNchar && inRun && credit == '0;   // Beyond granted credit
      if (loadNext)
      begin
        txValid_o <= 1'b1;
        nullPend  <= !nullPend && !fctDue;   // Never split a NULL pair
      end
    end
  end

  always_ff @(posedge gclk)
  begin
    if (enTx && loadNext)
      txKind_o <= (nullPend || fctDue) ? KindFct : KindEsc;
  end

endmodule

// ==== verilog/spwHostRegs.sv ====
////////////////////////////////////////////////////////////
// AXI4-Lite slave: control, status with sticky link error,
// and FIFO pop on a data register read
////////////////////////////////////////////////////////////

module spwHostRegs import spwPkg::*; (
  input  logic                gclk,
  input  logic                reset,
  input  logic                awvalid_i,
  output logic                awready_o,
  input  logic [RegAddrW-1:0] awaddr_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  input  logic [31:0]         wdata_i,
  output logic                bvalid_o,
  input  logic                bready_i,
  output logic [1:0]          bresp_o,
  input  logic                arvalid_i,
  output logic                arready_o,
  input  logic [RegAddrW-1:0] araddr_i,
  output logic                rvalid_o,
  input  logic                rready_i,
  output logic [31:0]         rdata_o,
  output logic [1:0]          rresp_o,
  input  spwState             linkState,
  input  logic                linkErr,
  input  spwNchar             popData,
  input  logic                empty,
  input  logic [7:0]          level,
  output logic                linkStart,
  output logic                linkDisable,
  output logic                autoStart,
  output logic                popEn
);

  logic                awSeen;       // AW taken, W still missing
  logic                wSeen;        // W taken, AW still missing
  logic [RegAddrW-1:0] awAddrQ;
  logic [31:0]         wDataQ;
  logic [RegAddrW-1:0] wrAddr;
  logic [31:0]         wrData;
  logic                awHs;
  logic                wHs;
  logic                arHs;
  logic                doWrite;
  logic [2:0]          ctrl;
  logic                errSticky;
  logic [31:0]         rdMux;

  assign bresp_o = 2'b00;            // Always OKAY
  assign rresp_o = 2'b00;

  assign {autoStart, linkDisable, linkStart} = ctrl;

  ////////////////////////////////////////////////////////////
  // Write path

  assign awready_o = !awSeen && !bvalid_o;
  assign wready_o  = !wSeen && !bvalid_o;
  assign awHs      = awvalid_i && awready_o;
  assign wHs       = wvalid_i && wready_o;
  assign doWrite   = (awSeen || awHs) && (wSeen || wHs);
  assign wrAddr    = awSeen ? awAddrQ : awaddr_i;
  assign wrData    = wSeen ? wDataQ : wdata_i;

  always_ff @(posedge gclk)
  begin
    if (reset)
    begin
      awSeen   <= 1'b0;
      wSeen    <= 1'b0;
      bvalid_o <= 1'b0;
      ctrl     <= '0;
    end
    else
    begin
      awSeen <= (awSeen || awHs) && !doWrite;
      wSeen  <= (wSeen || wHs) && !doWrite;
      if (doWrite)
        bvalid_o <= 1'b1;
      else if (bready_i)
        bvalid_o <= 1'b0;                 // Held until BREADY
      if (doWrite && wrAddr == RegCtrl)
        ctrl <= wrData[2:0];
    end
  end

  always_ff @(posedge gclk)
  begin
    if (awHs)
      awAddrQ <= awaddr_i;
    if (wHs)
      wDataQ <= wdata_i;
  end

  ////////////////////////////////////////////////////////////
  // Read path

  assign arready_o = !rvalid_o;
  assign arHs      = arvalid_i && arready_o;
  assign popEn     = arHs && araddr_i == RegData && !empty;   // One pop per read

  always_comb
  begin
    case (araddr_i)
      RegCtrl:   rdMux = {29'd0, ctrl};
      RegStatus: rdMux = {8'd0, level, 7'd0, errSticky, 2'd0, linkState};
      RegData:   rdMux = empty ? {1'b1, 31'd0}
                               : {1'b0, 21'd0, popData.endMark, popData.data};
      default:   rdMux = '0;
    endcase
  end

  always_ff @(posedge gclk)
  begin
    if (reset)
    begin
      rvalid_o  <= 1'b0;
      errSticky <= 1'b0;
    end
    else
    begin
      if (arHs)
        rvalid_o <= 1'b1;
      else if (rready_i)
        rvalid_o <= 1'b0;
      if (linkErr)
        errSticky <= 1'b1;                // New error wins over the clear
      else if (arHs && araddr_i == RegStatus)
        errSticky <= 1'b0;
    end
  end

  always_ff @(posedge gclk)
  begin
    if (arHs)
      rdata_o <= rdMux;
  end

endmodule

// ==== verilog/spwLinkTop.sv ====
////////////////////////////////////////////////////////////
// Link interface top: decoder, FIFO, link FSM, transmit
// encoder and AXI4-Lite registers
////////////////////////////////////////////////////////////

module spwLinkTop import spwPkg::*; #(
  parameter int ResetTicks = 10,
  parameter int WaitTicks  = 20,
  parameter int FifoDepth  = 16
) (
  input  logic                gclk,
  input  logic                reset,
  // Inbound characters
  input  logic                rxValid_i,
  input  spwCharKind          rxKind_i,
  input  logic [7:0]          rxData_i,
  input  logic                rxParity_i,
  input  logic                rxDisc_i,
  // Outbound characters
  output logic                txValid_o,
  output spwCharKind          txKind_o,
  input  logic                txReady_i,
  // AXI4-Lite slave
  input  logic                awvalid_i,
  output logic                awready_o,
  input  logic [RegAddrW-1:0] awaddr_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  input  logic [31:0]         wdata_i,
  output logic                bvalid_o,
  input  logic                bready_i,
  output logic [1:0]          bresp_o,
  input  logic                arvalid_i,
  output logic                arready_o,
  input  logic [RegAddrW-1:0] araddr_i,
  output logic                rvalid_o,
  input  logic                rready_i,
  output logic [31:0]         rdata_o,
  output logic [1:0]          rresp_o
);

  localparam int LevelW = $clog2(FifoDepth + 1);

  logic              pushValid;
  spwNchar           pushData;
  spwNchar           popData;
  logic              gotBit;
  logic              gotNull;
  logic              gotFct;
  logic              gotNchar;
  logic              gotTime;
  logic              errPar;
  logic              errEsc;
  logic              errCrd;
  logic              empty;
  logic              popEn;
  logic [LevelW-1:0] level;
  spwState           linkState;
  logic              enTx;
  logic              rstRx;
  logic              linkErr;
  logic              linkStart;
  logic              linkDisable;
  logic              autoStart;
  logic              inRun;

  assign inRun = linkState[5];   // One-hot Run bit

  spwRxDecoder rxDecoder (
    .gclk, .reset, .rstRx,
    .rxValid_i, .rxKind_i, .rxData_i, .rxParity_i, .inRun,
    .pushValid, .pushData,
    .gotBit, .gotNull, .gotFct, .gotNchar, .gotTime, .errPar, .errEsc
  );

  spwRxFifo #(.PayloadT(spwNchar), .FifoDepth(FifoDepth)) rxFifo (
    .gclk, .reset, .flush(rstRx),   // Contents lost on ErrorReset
    .pushValid, .pushData, .popEn,
    .popData, .empty, .level
  );

  spwLinkFsm #(.ResetTicks(ResetTicks), .WaitTicks(WaitTicks)) linkFsm (
    .gclk, .reset,
    .linkStart, .linkDisable, .autoStart, .rxDisc(rxDisc_i),
    .gotBit, .gotNull, .gotFct, .gotNchar, .gotTime, .errPar, .errEsc, .errCrd,
    .linkState, .enTx, .rstRx, .linkErr
  );

  spwTxEncoder #(.FifoDepth(FifoDepth)) txEncoder (
    .gclk, .reset, .enTx, .inRun, .gotNchar, .level,
    .txReady_i, .txValid_o, .txKind_o, .errCrd
  );

  spwHostRegs hostRegs (
    .gclk, .reset,
    .awvalid_i, .awready_o, .awaddr_i,
    .wvalid_i, .wready_o, .wdata_i,
    .bvalid_o, .bready_i, .bresp_o,
    .arvalid_i, .arready_o, .araddr_i,
    .rvalid_o, .rready_i, .rdata_o, .rresp_o,
    .linkState, .linkErr, .popData, .empty,
    .level(8'(level)),             // Status field is 8 bits
    .linkStart, .linkDisable, .autoStart, .popEn
  );

endmodule

// ==== test/spwLink_sva.sv ====
////////////////////////////////////////////////////////////
// Link FSM assertions: one-hot state, transmit enable and
// link error pulse, bound into spwLinkFsm
////////////////////////////////////////////////////////////

module spwLinkFsmChecks import spwPkg::*; (
  input logic    gclk,
  input logic    reset,
  input spwState linkState,
  input logic    enTx,
  input logic    linkErr
);

  stateOneHot: assert property (@(posedge gclk) disable iff (reset) $onehot(linkState))
    else $error("Link state is not one-hot");

  // Transmitter only starts on the Ready to Started step
  enTxStates: assert property (@(posedge gclk) disable iff (reset)
    $rose(enTx) |-> linkState == StStarted && $past(linkState) == StReady)
    else $error("enTx rose other than on entry to Started from Ready");

  errFromRun: assert property (@(posedge gclk) disable iff (reset)
    linkErr |-> linkState == StRun ##1 linkState == StErrorReset)
    else $error("linkErr pulsed without leaving Run for ErrorReset");

endmodule

bind spwLinkFsm spwLinkFsmChecks fsmChecks (.gclk, .reset, .linkState, .enTx, .linkErr);

// ==== test/spwLinkTb.sv ====
////////////////////////////////////////////////////////////
// Link interface testbench: clock and reset, AXI4-Lite and
// character drivers, reference model, read compare, tx monitor
////////////////////////////////////////////////////////////

module spwLinkTb import spwPkg::*; ();

  localparam int ResetTicks = 10;
  localparam int WaitTicks  = 20;
  localparam int FifoDepth  = 16;
  localparam int WaitLimit  = 200;   // Cycles for one handshake
  localparam int PollLimit  = 300;   // Status reads for one state
  localparam logic [1:0] RespOkay = 2'b00;

  logic                gclk;
  logic                reset;
  logic                rxValid_i;
  spwCharKind          rxKind_i;
  logic [7:0]          rxData_i;
  logic                rxParity_i;
  logic                rxDisc_i;
  logic                txValid_o;
  spwCharKind          txKind_o;
  logic                txReady_i;
  logic                awvalid_i;
  logic                awready_o;
  logic                wvalid_i;
  logic                wready_o;
  logic                bvalid_o;
  logic                bready_i;
  logic [RegAddrW-1:0] awaddr_i;
  logic [RegAddrW-1:0] araddr_i;
  logic [31:0]         wdata_i;
  logic [31:0]         rdata_o;
  logic [1:0]          bresp_o;
  logic [1:0]          rresp_o;
  logic                arvalid_i;
  logic                arready_o;
  logic                rvalid_o;
  logic                rready_i;

  int          errors;
  int          checks;
  int          testsRun;
  int          testsBad;
  int          testStart;
  int          cycle;
  int          nullPairs;     // ESC+FCT pairs sent by the DUT
  int          loneFct;       // Plain FCTs sent by the DUT
  int          runFct;        // Plain FCTs since the transmitter was enabled
  logic        prevEsc;
  logic        stalled;
  spwCharKind  stallKind;
  logic [9:0]  refQ[$];       // Expected N-chars, {endMark, data}
  logic [31:0] expQ[$];
  logic [31:0] actQ[$];
  logic [3:0]  addrQ[$];
  logic [31:0] cmpExp;
  logic [31:0] cmpAct;
  logic [3:0]  cmpAddr;

  spwLinkTop #(.ResetTicks(ResetTicks), .WaitTicks(WaitTicks), .FifoDepth(FifoDepth)) dut (
    .gclk, .reset,
    .rxValid_i, .rxKind_i, .rxData_i, .rxParity_i, .rxDisc_i,
    .txValid_o, .txKind_o, .txReady_i,
    .awvalid_i, .awready_o, .awaddr_i, .wvalid_i, .wready_o, .wdata_i,
    .bvalid_o, .bready_i, .bresp_o,
    .arvalid_i, .arready_o, .araddr_i, .rvalid_o, .rready_i, .rdata_o, .rresp_o
  );

  initial
  begin
    gclk = 1'b0;
    forever #10 gclk = ~gclk;
  end

  always @(posedge gclk)
    cycle <= cycle + 1;

  // Random back-pressure on the outbound stream
  always @(negedge gclk)
    txReady_i = ($urandom % 4) != 0;

  ////////////////////////////////////////////////////////////
  // Reference model

  // Next RegData word from the N-chars sent in Run
  function automatic logic [31:0] expectNext();
    logic [9:0] item;
    if (refQ.size() == 0)
      return {1'b1, 31'd0};               // Empty flag only
    item = refQ.pop_front();
    return {1'b0, 21'd0, item};
  endfunction

  function automatic logic [31:0] expectStatus(spwState st, logic err, int lvl);
    return {8'd0, 8'(lvl), 7'd0, err, 2'd0, st};
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare process and transmit monitor

  always @(posedge gclk)
  begin
    while (actQ.size() > 0)
    begin
      cmpAct  = actQ.pop_front();
      cmpExp  = expQ.pop_front();
      cmpAddr = addrQ.pop_front();
      checks++;
      assert (cmpAct == cmpExp)
      else
      begin
        errors++;
        $display("Error at %0t: rdata_o (offset 0x%0h) got 0x%08h expected 0x%08h",
                 $time, cmpAddr, cmpAct, cmpExp);
      end
    end
  end

  always @(posedge gclk)
  begin
    if (reset || !txValid_o)
    begin
      prevEsc <= 1'b0;
      runFct  <= 0;
      stalled <= 1'b0;
    end
    else
    begin
      if (stalled)
      begin
        checks++;
        assert (txKind_o == stallKind)   // Held while not accepted
        else
        begin
          errors++;
          $display("Error at %0t: txKind_o got %0d expected %0d", $time, txKind_o, stallKind);
        end
      end
      stalled   <= !txReady_i;
      stallKind <= txKind_o;
      if (txReady_i)
      begin
        if (txKind_o == KindFct && prevEsc)
          nullPairs <= nullPairs + 1;
        else if (txKind_o == KindFct)
        begin
          loneFct <= loneFct + 1;
          runFct  <= runFct + 1;
        end
        prevEsc <= txKind_o == KindEsc;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Drivers

  task automatic timeoutAbort(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic checkTrue(input logic cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("Check failed at %0t: %s", $time, what);
    end
  endtask

  task automatic compareField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got == exp)
    else
    begin
      errors++;
      $display("Error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data);
    int   n;
    logic awDone;
    logic wDone;
    @(negedge gclk);
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    awDone    = 1'b0;
    wDone     = 1'b0;
    n         = 0;
    while (!(awDone && wDone))
    begin
      @(posedge gclk);
      if (awvalid_i && awready_o)
        awDone = 1'b1;
      if (wvalid_i && wready_o)
        wDone = 1'b1;
      n++;
      if (n > WaitLimit)
        timeoutAbort("AXI write address and data");
      @(negedge gclk);
      if (awDone)
        awvalid_i = 1'b0;
      if (wDone)
        wvalid_i = 1'b0;
    end
    n = 0;
    while (!bvalid_o)
    begin
      @(negedge gclk);
      n++;
      if (n > WaitLimit)
        timeoutAbort("AXI write response");
    end
    compareField("bresp_o", bresp_o, RespOkay);
  endtask

  task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
    int n;
    @(negedge gclk);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    n         = 0;
    do
    begin
      @(posedge gclk);
      n++;
      if (n > WaitLimit)
        timeoutAbort("AXI read address");
    end
    while (!arready_o);
    @(negedge gclk);
    arvalid_i = 1'b0;
    n = 0;
    while (!rvalid_o)
    begin
      @(negedge gclk);
      n++;
      if (n > WaitLimit)
        timeoutAbort("AXI read data");
    end
    data = rdata_o;                    // Stable at the falling edge
    compareField("rresp_o", rresp_o, RespOkay);
  endtask

  task automatic readCheck(input logic [3:0] addr, input logic [31:0] exp);
    logic [31:0] d;
    axiRead(addr, d);
    addrQ.push_back(addr);
    expQ.push_back(exp);
    actQ.push_back(d);
  endtask

  task automatic waitState(input spwState st, input string what);
    logic [31:0] d;
    int          n;
    n = 0;
    do
    begin
      axiRead(RegStatus, d);
      n++;
      if (n > PollLimit)
        timeoutAbort(what);
    end
    while (d[5:0] != st);
  endtask

  task automatic waitFcts(input int cnt);
    int n;
    n = 0;
    while (runFct < cnt)
    begin
      @(negedge gclk);
      n++;
      if (n > WaitLimit)
        timeoutAbort("FCTs from the transmitter");
    end
  endtask

  // One character per call, held for one cycle
  task automatic sendChar(input spwCharKind kind, input logic [7:0] data, input logic bad);
    @(negedge gclk);
    rxValid_i  = 1'b1;
    rxKind_i   = kind;
    rxData_i   = data;
    rxParity_i = ~(^data) ^ bad;       // Odd parity unless bad
  endtask

  task automatic lineIdle();
    @(negedge gclk);
    rxValid_i = 1'b0;
  endtask

  task automatic sendNull();
    sendChar(KindEsc, 8'h00, 1'b0);
    sendChar(KindFct, 8'h00, 1'b0);
    lineIdle();
  endtask

  task automatic reachRun();
    waitState(StStarted, "Started");
    sendNull();
    waitState(StConnecting, "Connecting");
    sendChar(KindFct, 8'h00, 1'b0);
    lineIdle();
    waitState(StRun, "Run");
  endtask

  task automatic finishTest(input string name);
    repeat (2) @(negedge gclk);        // Let the compare process drain
    testsRun++;
    if (errors != testStart)
      testsBad++;
    $display("Test %s: %s", name, (errors == testStart) ? "ok" : "errors found");
    testStart = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    int          grant;
    int          errCycle;
    logic [7:0]  d;
    spwCharKind  kind;
    logic [1:0]  mark;
    void'($urandom(32'h266a2b1a));
    errors     = 0;
    checks     = 0;
    testsRun   = 0;
    testsBad   = 0;
    testStart  = 0;
    cycle      = 0;
    nullPairs  = 0;
    loneFct    = 0;
    reset      = 1'b1;
    rxValid_i  = 1'b0;
    rxKind_i   = KindData;
    rxData_i   = '0;
    rxParity_i = 1'b0;
    rxDisc_i   = 1'b0;
    txReady_i  = 1'b1;
    awvalid_i  = 1'b0;
    awaddr_i   = '0;
    wvalid_i   = 1'b0;
    wdata_i    = '0;
    bready_i   = 1'b1;
    arvalid_i  = 1'b0;
    araddr_i   = '0;
    rready_i   = 1'b1;
    repeat (4) @(posedge gclk);
    @(negedge gclk);
    reset = 1'b0;

    // Startup to Run
    axiWrite(RegCtrl, 32'h1);
    reachRun();
    waitFcts(2);
    checkTrue(nullPairs > 0, "no NULL was sent before Run");
    checkTrue(loneFct > 0, "no FCT was sent in Run");
    readCheck(RegStatus, expectStatus(StRun, 1'b0, 0));
    finishTest("startup");

    // Data path, 12 N-chars within 16 of credit
    for (int i = 0; i < 12; i++)
    begin
      kind = (i == 5) ? KindEop : (i == 11) ? KindEep : KindData;
      mark = (i == 5) ? EndEop : (i == 11) ? EndEep : EndNone;
      d    = 8'($urandom);
      sendChar(kind, d, 1'b0);
      refQ.push_back({mark, d});
    end
    lineIdle();
    repeat (3) @(negedge gclk);
    readCheck(RegStatus, expectStatus(StRun, 1'b0, 12));
    for (int i = 0; i < 13; i++)
      readCheck(RegData, expectNext());
    readCheck(RegStatus, expectStatus(StRun, 1'b0, 0));
    finishTest("data path");

    // Parity error in Run, then both timeouts and a restart
    sendChar(KindData, 8'h5a, 1'b1);
    lineIdle();
    errCycle = cycle;
    repeat (3) @(negedge gclk);
    readCheck(RegStatus, expectStatus(StErrorReset, 1'b1, 0));
    waitState(StStarted, "Started after a link error");
    checkTrue(cycle - errCycle >= ResetTicks + WaitTicks + 2,
              "Started was reached before the reset and wait timeouts");
    sendNull();
    waitState(StConnecting, "Connecting after a link error");
    sendChar(KindFct, 8'h00, 1'b0);
    lineIdle();
    waitState(StRun, "Run after a link error");
    finishTest("run error");

    // N-char in Connecting is a silent sequence error
    axiWrite(RegCtrl, 32'h2);
    axiWrite(RegCtrl, 32'h1);
    waitState(StStarted, "Started");
    sendNull();
    waitState(StConnecting, "Connecting");
    sendChar(KindData, 8'($urandom), 1'b0);
    lineIdle();
    repeat (2) @(negedge gclk);
    readCheck(RegStatus, expectStatus(StErrorReset, 1'b0, 0));
    finishTest("sequence error");

    // One N-char past the granted credit, then disable over start
    reachRun();
    waitFcts(2);
    grant = runFct * 8;
    for (int i = 0; i <= grant; i++)
      sendChar(KindData, 8'($urandom), 1'b0);
    lineIdle();
    repeat (3) @(negedge gclk);
    readCheck(RegStatus, expectStatus(StErrorReset, 1'b1, 0));
    axiWrite(RegCtrl, 32'h3);
    repeat (3) @(negedge gclk);
    for (int i = 0; i < 60; i++)
    begin
      @(negedge gclk);
      compareField("txValid_o", txValid_o, 1'b0);
    end
    readCheck(RegStatus, expectStatus(StErrorReset, 1'b0, 0));
    finishTest("credit and disable");

    $display("Tests %0d, with errors %0d, checks %0d, errors %0d",
             testsRun, testsBad, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== spwLink.f ====
verilog/spwPkg.sv
verilog/spwRxDecoder.sv
verilog/spwRxFifo.sv
verilog/spwLinkFsm.sv
verilog/spwTxEncoder.sv
verilog/spwHostRegs.sv
verilog/spwLinkTop.sv
test/spwLink_sva.sv
test/spwLinkTb.sv

// ==== Bender.yml ====
package:
  name: spwLink

sources:
  - verilog/spwPkg.sv
  - verilog/spwRxDecoder.sv
  - verilog/spwRxFifo.sv
  - verilog/spwLinkFsm.sv
  - verilog/spwTxEncoder.sv
  - verilog/spwHostRegs.sv
  - verilog/spwLinkTop.sv
  - target: test
    files:
      - test/spwLink_sva.sv
      - test/spwLinkTb.sv
